// File: mouse_patterns.txt
// columns (hex): byte0 byte1 byte2 code gap_cycles
// code 0 none, 1 parity, 2 stop, 3 start, 4 partial frame, 5 clock glitches, ff end
08 00 00 0 20
09 10 05 0 20
0A 00 00 0 30
18 F0 02 0 20
28 03 FE 0 20
38 80 80 0 20
3B FF FF 0 20
08 7F 7F 0 20
09 11 22 1 20
0A 33 44 2 20
0B 55 66 3 20
08 01 01 0 20
19 AA BB 4 12C
28 12 34 0 20
09 21 43 5 20
3A 9C C8 5 20
0B 44 0C 1 20
18 01 80 0 40
00 00 00 ff 0

// File: src.f
mouse_pkg.sv
ps2_line_if.sv
ps2_line_sync.sv
ps2_mouse_host.sv
mouse_report_decoder.sv
ps2_mouse_top.sv
tb_clock_gen.sv
tb_ps2_mouse.sv

// File: Makefile
# Verilator build and run of the PS/2 mouse testbench

VERILATOR ?= verilator
TOP       ?= tb_ps2_mouse
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
PATTERNS  ?= mouse_patterns.txt
VFLAGS    ?= --binary --timing --assert -Wno-fatal
JOBS      ?= 4

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR PATTERNS VFLAGS JOBS"

test: $(SIM_BIN) $(PATTERNS)
	./$(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: tb_ps2_mouse.sv
/*
 * Testbench for ps2_mouse_top with a PS/2 mouse bus model (wired-AND lines).
 * Packets come from mouse_patterns.txt, run from the project root.
 * Stops at the first mismatch; the watchdog limit scales with the pattern count.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ps2_mouse;

    import mouse_pkg::*;

    localparam int DEBOUNCE = 3;
    localparam int INHIBIT  = 40;
    localparam int IDLE     = 200;
    localparam int HOLD     = 100;
    localparam int PS2_PER  = 40;          // system cycles per PS/2 clock
    localparam int HALF     = PS2_PER / 2;
    localparam int MAX_PAT  = 64;
    localparam int SEED     = 32'hfb7c_c584;

    logic              clk;
    logic              rst_n;
    logic              model_clk_pull;     // mouse side pull-low enables
    logic              model_data_pull;
    logic              ps2_clk;
    logic              ps2_data;
    logic              host_clk_pull;
    logic              host_data_pull;
    logic              btn_left;
    logic              btn_right;
    logic signed [8:0] move_x;
    logic signed [8:0] move_y;
    logic              valid;
    logic              activity;
    logic [15:0]       pat_mem [0:5*MAX_PAT-1]; // b0 b1 b2 code gap per pattern
    int                valid_cnt = 0;
    int                cycle_cnt = 0;
    int                cycle_limit = 0;        // 0 until patterns are counted

    // open-drain bus where either side pulls low
    assign ps2_clk  = !(host_clk_pull || model_clk_pull);
    assign ps2_data = !(host_data_pull || model_data_pull);

    tb_clock_gen #(.PERIOD_NS(4), .RESET_CYCLES(3)) clkgen0 (.o_clk(clk), .o_rst_n(rst_n));

    ps2_mouse_top #(
        .DEBOUNCE_CYCLES      (DEBOUNCE),
        .INHIBIT_CYCLES       (INHIBIT),
        .IDLE_TIMEOUT_CYCLES  (IDLE),
        .ACTIVITY_HOLD_CYCLES (HOLD)
    ) dut0 (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_ps2_clk       (ps2_clk),
        .i_ps2_data      (ps2_data),
        .o_ps2_clk_pull  (host_clk_pull),
        .o_ps2_data_pull (host_data_pull),
        .o_button_left   (btn_left),
        .o_button_right  (btn_right),
        .o_movement_x    (move_x),
        .o_movement_y    (move_y),
        .o_valid         (valid),
        .o_activity      (activity)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic report_mismatch(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic check_bit(input logic exp, input logic act, input string what);
        if (act !== exp)
            report_mismatch($sformatf("%s: expected %b, got %b", what, exp, act));
    endtask

    task automatic check_count(input int exp, input int act, input string what);
        if (act != exp)
            report_mismatch($sformatf("%s: expected %0d, got %0d", what, exp, act));
    endtask

    task automatic check_report(input mouse_report_t exp, input string what);
        mouse_report_t got;
        got.btn_left  = btn_left;
        got.btn_right = btn_right;
        got.move_x    = move_x;
        got.move_y    = move_y;
        if (got !== exp)
            report_mismatch($sformatf("%s: expected L%b R%b x=%0d y=%0d, got L%b R%b x=%0d y=%0d",
                what, exp.btn_left, exp.btn_right, exp.move_x, exp.move_y,
                got.btn_left, got.btn_right, got.move_x, got.move_y));
    endtask

    // inputs change 1 ns after the rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // stop, odd parity, data, start
    function automatic logic [10:0] make_char(input logic [7:0] b);
        return {1'b1, ~^b, b, 1'b0};
    endfunction

    // buttons in byte 0 and sign bits 4 and 5 of byte 0 extend x and y
    function automatic mouse_report_t decode_bytes(input logic [7:0] b0, b1, b2);
        mouse_report_t r;
        r.btn_left  = b0[0];
        r.btn_right = b0[1];
        r.move_x    = {b0[4], b1};
        r.move_y    = {b0[5], b2};
        return r;
    endfunction

    // one PS/2 clock per bit with data changed while the clock is high
    task automatic send_bits(input logic [FRAME_BITS-1:0] bits, input int nbits,
                             input bit glitch);
        int g;
        for (int i = 0; i < nbits; i++) begin
            model_data_pull = !bits[i];
            if (glitch) begin
                g = 1 + int'($urandom % 2); // short enough for the debouncer
                wait_cycles(8);
                model_clk_pull = 1'b1;
                wait_cycles(g);
                model_clk_pull = 1'b0;
                wait_cycles(HALF - 8 - g);
            end else begin
                wait_cycles(HALF);
            end
            model_clk_pull = 1'b1; // falling edge where the host samples
            wait_cycles(HALF);
            model_clk_pull = 1'b0;
        end
        model_data_pull = 1'b0;
    endtask

    always @(posedge clk) begin
        if (valid === 1'b1)
            valid_cnt <= valid_cnt + 1;
    end

    // watchdog
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit)
            abort_run($sformatf("timeout: run still busy after %0d cycles", cycle_cnt));
    end

    initial begin
        int                    npat;
        int                    inh;
        int                    cnt0;
        int                    gap;
        logic [7:0]            b0;
        logic [7:0]            b1;
        logic [7:0]            b2;
        logic [7:0]            code;
        logic [9:0]            cmd_bits;
        logic [FRAME_BITS-1:0] frame;
        mouse_report_t         last_exp;

        model_clk_pull  = 1'b0;
        model_data_pull = 1'b0;
        void'($urandom(SEED));
        $readmemh("mouse_patterns.txt", pat_mem);
        npat = 0;
        while (npat < MAX_PAT && pat_mem[npat*5+3] !== 16'h00ff) begin
            if ($isunknown(pat_mem[npat*5+3]))
                abort_run("pattern file missing, or its end marker is missing");
            npat++;
        end
        if (npat == 0)
            abort_run("pattern file holds no packets");
        cycle_limit = npat * 33 * PS2_PER * 2 + INHIBIT + 11 * PS2_PER + HOLD + 1000;

        // inhibit time, then 10 bits clocked by the mouse
        @(posedge rst_n);
        check_bit(1'b0, valid, "valid after reset");
        check_bit(1'b0, activity, "activity after reset");
        inh = 0;
        while (ps2_clk === 1'b0) begin
            check_bit(1'b0, host_data_pull, "data pull during inhibit");
            inh++;
            wait_cycles(1);
        end
        check_bit(1'b1, inh >= INHIBIT, "clock held low for the inhibit time");
        cmd_bits = {1'b0, 8'hF4, 1'b0}; // F4 has five ones so odd parity is 0
        for (int k = 0; k < 10; k++) begin
            wait_cycles(HALF);
            check_bit(cmd_bits[k], ps2_data, $sformatf("command bit %0d", k));
            model_clk_pull = 1'b1;
            wait_cycles(HALF);
            model_clk_pull = 1'b0;
        end
        wait_cycles(HALF);
        check_bit(1'b0, host_data_pull, "data pull after tenth bit");
        check_bit(1'b0, host_clk_pull, "clock pull after command");

        last_exp = '0;
        for (int p = 0; p < npat; p++) begin
            b0   = pat_mem[p*5][7:0];
            b1   = pat_mem[p*5+1][7:0];
            b2   = pat_mem[p*5+2][7:0];
            code = pat_mem[p*5+3][7:0];
            gap  = int'(pat_mem[p*5+4]);
            frame = {make_char(b2), make_char(b1), make_char(b0)};
            cnt0 = valid_cnt;
            if (code == 8'd4) begin
                send_bits(frame, 12, 1'b0); // partial frame that the idle gap drops
                wait_cycles(gap);
                check_count(cnt0, valid_cnt, "valid pulses after partial frame");
            end else begin
                case (code)
                    8'd1: frame[31] = ~frame[31]; // byte 2 parity
                    8'd2: frame[21] = 1'b0;       // byte 1 stop
                    8'd3: frame[0]  = 1'b1;       // byte 0 start
                    default: ;
                endcase
                send_bits(frame, FRAME_BITS, code == 8'd5);
                if (code == 8'd0 || code == 8'd5) begin
                    last_exp = decode_bytes(b0, b1, b2);
                    check_count(cnt0 + 1, valid_cnt, $sformatf("valid pulses, pattern %0d", p));
                end else begin
                    check_count(cnt0, valid_cnt, $sformatf("valid pulses, pattern %0d", p));
                end
                check_report(last_exp, $sformatf("report, pattern %0d", p));
                check_bit(1'b1, activity, $sformatf("activity, pattern %0d", p));
                wait_cycles(gap + int'($urandom % 16));
            end
        end

        wait_cycles(HOLD + 1);
        check_bit(1'b0, activity, "activity after hold time");
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
/*
 * Testbench clock and reset source.
 * Reset is active low and released 1 ns after the last reset edge.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 3
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1 o_rst_n = 1'b1; // same skew as the other stimulus
    end

endmodule

`default_nettype wire

// File: ps2_mouse_top.sv
/*
 * PS/2 mouse receiver top. PS/2 lines are split into sensed inputs and
 * pull-low enables; the board or testbench forms the wired-AND bus.
 * Defaults assume a 50 MHz system clock.
 */
`timescale 1ns/1ps
`default_nettype none

module ps2_mouse_top #(
    parameter int unsigned DEBOUNCE_CYCLES      = 16,       // ~320 ns
    parameter int unsigned INHIBIT_CYCLES       = 6000,     // 120 us, spec wants >100 us
    parameter int unsigned IDLE_TIMEOUT_CYCLES  = 30000,    // 600 us
    parameter int unsigned ACTIVITY_HOLD_CYCLES = 30000000  // 0.6 s
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_ps2_clk,
    input  logic              i_ps2_data,
    output logic              o_ps2_clk_pull,
    output logic              o_ps2_data_pull,
    output logic              o_button_left,
    output logic              o_button_right,
    output logic signed [8:0] o_movement_x,
    output logic signed [8:0] o_movement_y,
    output logic              o_valid,
    output logic              o_activity
);

    import mouse_pkg::*;

    ps2_line_if            line ();
    logic [FRAME_BITS-1:0] frame;
    logic                  frame_done;
    mouse_report_t         report;

    ps2_line_sync #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) sync0 (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_ps2_clk  (i_ps2_clk),
        .i_ps2_data (i_ps2_data),
        .line       (line.sync)
    );

    ps2_mouse_host #(
        .INHIBIT_CYCLES      (INHIBIT_CYCLES),
        .IDLE_TIMEOUT_CYCLES (IDLE_TIMEOUT_CYCLES)
    ) host0 (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .line            (line.host),
        .o_ps2_clk_pull  (o_ps2_clk_pull),
        .o_ps2_data_pull (o_ps2_data_pull),
        .o_frame         (frame),
        .o_frame_done    (frame_done)
    );

    mouse_report_decoder #(
        .ACTIVITY_HOLD_CYCLES (ACTIVITY_HOLD_CYCLES)
    ) dec0 (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_frame      (frame),
        .i_frame_done (frame_done),
        .o_report     (report),
        .o_valid      (o_valid),
        .o_activity   (o_activity)
    );

    // flatten report onto plain pins
    assign o_button_left  = report.btn_left;
    assign o_button_right = report.btn_right;
    assign o_movement_x   = report.move_x;
    assign o_movement_y   = report.move_y;

endmodule

`default_nettype wire

// File: mouse_report_decoder.sv
/*
 * Checks start, stop and odd parity of all three bytes of a frame.
 * Report only updates for frames that pass; rejected frames keep the old one.
 * o_activity stays high ACTIVITY_HOLD_CYCLES after any frame, good or bad.
 */
`timescale 1ns/1ps
`default_nettype none

module mouse_report_decoder #(
    parameter int unsigned ACTIVITY_HOLD_CYCLES = 30000000
) (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  logic [mouse_pkg::FRAME_BITS-1:0] i_frame,
    input  logic                             i_frame_done,
    output mouse_pkg::mouse_report_t         o_report,
    output logic                             o_valid,
    output logic                             o_activity
);

    import mouse_pkg::*;

    localparam int unsigned ACT_W = $clog2(ACTIVITY_HOLD_CYCLES + 1);

    logic             frame_ok;
    mouse_report_t    report_d;
    logic [ACT_W-1:0] act_cnt; // saturates at the hold value

    // characters start at bits 0, 11 and 22
    // each holds start, 8 data, parity and stop
    assign frame_ok = !i_frame[0] && !i_frame[11] && !i_frame[22]
                   && i_frame[10] && i_frame[21] && i_frame[FRAME_BITS-1]
                   && (^i_frame[9:1])    // data plus parity must be odd
                   && (^i_frame[20:12])
                   && (^i_frame[31:23]);

    always_comb begin
        report_d.btn_left  = i_frame[1];  // byte 0 bit 0
        report_d.btn_right = i_frame[2];  // byte 0 bit 1
        report_d.move_x    = {i_frame[5], i_frame[19:12]}; // sign bit and byte 1
        report_d.move_y    = {i_frame[6], i_frame[30:23]}; // sign bit and byte 2
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_report <= '0;
            o_valid  <= 1'b0;
        end else begin
            o_valid <= i_frame_done && frame_ok;
            if (i_frame_done && frame_ok) begin
                o_report <= report_d;
            end
        end
    end

    // restarts on every frame and stops at the hold value
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            act_cnt <= ACT_W'(ACTIVITY_HOLD_CYCLES);
        end else if (i_frame_done) begin
            act_cnt <= '0;
        end else if (act_cnt != ACT_W'(ACTIVITY_HOLD_CYCLES)) begin
            act_cnt <= act_cnt + 1'b1;
        end
    end

    assign o_activity = (act_cnt != ACT_W'(ACTIVITY_HOLD_CYCLES));

    // a good frame always shows as activity too
    a_valid_active: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_valid |-> o_activity);

endmodule

`default_nettype wire

// File: ps2_mouse_host.sv
/*
 * PS/2 host engine. Sends 0xF4 once after reset, then shifts in 33-bit frames.
 * Device acknowledge and 0xFA reply are not checked; the idle timeout
 * drops any partial frame they leave behind.
 * Pull outputs are open-drain enables, high means drive the line low.
 */
`timescale 1ns/1ps
`default_nettype none

module ps2_mouse_host #(
    parameter int unsigned INHIBIT_CYCLES      = 6000,
    parameter int unsigned IDLE_TIMEOUT_CYCLES = 30000
) (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    ps2_line_if.host                        line,
    output logic                            o_ps2_clk_pull,
    output logic                            o_ps2_data_pull,
    output logic [mouse_pkg::FRAME_BITS-1:0] o_frame,
    output logic                            o_frame_done
);

    import mouse_pkg::*;

    localparam int unsigned CNT_MAX = (INHIBIT_CYCLES > IDLE_TIMEOUT_CYCLES) ?
                                      INHIBIT_CYCLES : IDLE_TIMEOUT_CYCLES;
    localparam int unsigned CNT_W   = $clog2(CNT_MAX + 1);
    localparam int unsigned BIT_W   = $clog2(FRAME_BITS);

    // start 0, data LSB first, odd parity
    // the stop bit comes from releasing data
    localparam logic [9:0] CMD_BITS = {~(^CMD_ENABLE_REPORTING),
                                       CMD_ENABLE_REPORTING, 1'b0};

    host_state_t             state;
    logic [CNT_W-1:0]        cyc_cnt;   // inhibit time and later idle gap
    logic [BIT_W-1:0]        bit_cnt;
    logic [FRAME_BITS-1:0]   shreg;     // command out and frames in
    logic [FRAME_BITS-1:0]   frame_q;   // last complete frame
    logic                    last_bit;

    assign last_bit = (bit_cnt == BIT_W'(FRAME_BITS - 1));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= ST_HOLD_CLK;
            cyc_cnt <= '0;
            bit_cnt <= '0;
            shreg   <= '0;
        end else begin
            case (state)
                ST_HOLD_CLK: begin
                    if (cyc_cnt == CNT_W'(INHIBIT_CYCLES - 1)) begin
                        state   <= ST_SEND_CMD;
                        cyc_cnt <= '0;
                        bit_cnt <= '0;
                        shreg   <= FRAME_BITS'(CMD_BITS); // start bit on [0]
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                ST_SEND_CMD: begin
                    if (line.clk_fall) begin
                        if (bit_cnt == BIT_W'(9)) begin
                            state   <= ST_RECEIVE; // tenth fall releases data
                            bit_cnt <= '0;
                            cyc_cnt <= '0;
                        end else begin
                            shreg   <= {1'b0, shreg[FRAME_BITS-1:1]};
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                ST_RECEIVE: begin
                    if (line.clk_fall) begin
                        shreg   <= {line.data_level, shreg[FRAME_BITS-1:1]}; // LSB first
                        cyc_cnt <= '0;
                        if (last_bit) begin
                            state   <= ST_FRAME_DONE;
                            bit_cnt <= '0;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else if (cyc_cnt == CNT_W'(IDLE_TIMEOUT_CYCLES - 1)) begin
                        bit_cnt <= '0; // long gap drops the partial frame
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                ST_FRAME_DONE: begin
                    state   <= ST_RECEIVE;
                    cyc_cnt <= '0;
                end
                default: state <= ST_HOLD_CLK;
            endcase
        end
    end

    // captured on the 33rd fall and held until the next frame
    always_ff @(posedge i_clk) begin
        if (state == ST_RECEIVE && line.clk_fall && last_bit) begin
            frame_q <= {line.data_level, shreg[FRAME_BITS-1:1]};
        end
    end

    assign o_frame         = frame_q;
    assign o_frame_done    = (state == ST_FRAME_DONE);
    assign o_ps2_clk_pull  = (state == ST_HOLD_CLK);         // inhibit
    assign o_ps2_data_pull = (state == ST_SEND_CMD) && !shreg[0]; // 1 bits float high

    // frame output only moves together with its strobe
    a_frame_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $changed(o_frame) |-> o_frame_done);

    // inhibit happens once after reset and the clock is never pulled again
    a_clk_once: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !o_ps2_clk_pull |=> !o_ps2_clk_pull);

    // edge pulses agree with the debounced level from the line side
    a_edge_level: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (line.clk_fall |-> !line.clk_level) and (line.clk_rise |-> line.clk_level));

endmodule

`default_nettype wire

// File: ps2_line_sync.sv
/*
 * Two-flop synchronizers on both PS/2 lines, debounce on the clock.
 * Clock level follows the raw line only after DEBOUNCE_CYCLES stable cycles,
 * so shorter glitches never produce an edge pulse.
 */
`timescale 1ns/1ps
`default_nettype none

module ps2_line_sync #(
    parameter int unsigned DEBOUNCE_CYCLES = 16
) (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_ps2_clk,   // sensed clock line
    input  logic     i_ps2_data,  // sensed data line
    ps2_line_if.sync line
);

    localparam int unsigned DB_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [1:0]      clk_sync;    // [1] is the usable stage
    logic [1:0]      data_sync;
    logic [DB_W-1:0] db_cnt;      // consecutive cycles raw != level
    logic            clk_level;
    logic            clk_fall;
    logic            clk_rise;

    // lines idle high so the sync chain resets to 1
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
        end else begin
            clk_sync  <= {clk_sync[0], i_ps2_clk};
            data_sync <= {data_sync[0], i_ps2_data};
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            clk_level <= 1'b1;
            db_cnt    <= '0;
            clk_fall  <= 1'b0;
            clk_rise  <= 1'b0;
        end else begin
            clk_fall <= 1'b0; // pulses by default
            clk_rise <= 1'b0;
            if (clk_sync[1] == clk_level) begin
                db_cnt <= '0; // short glitch restarts the count
            end else if (db_cnt == DB_W'(DEBOUNCE_CYCLES - 1)) begin
                db_cnt    <= '0;
                clk_level <= clk_sync[1];  // accept new level
                clk_fall  <= !clk_sync[1];
                clk_rise  <= clk_sync[1];
            end else begin
                db_cnt <= db_cnt + 1'b1;
            end
        end
    end

    assign line.clk_level  = clk_level;
    assign line.clk_fall   = clk_fall;
    assign line.clk_rise   = clk_rise;
    assign line.data_level = data_sync[1]; // same 2-flop delay as clock

    // an accepted edge needs the new raw level for the whole debounce time
    a_edge_debounced: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (line.clk_fall || line.clk_rise) |->
            $past(clk_sync[1], DEBOUNCE_CYCLES) == line.clk_level);

endmodule

`default_nettype wire

// File: ps2_line_if.sv
/*
 * Conditioned PS/2 line signals, input side to host engine.
 * clk_fall and clk_rise are single-cycle pulses.
 * data_level is stable in the clk_fall cycle.
 */
`timescale 1ns/1ps
`default_nettype none

interface ps2_line_if;

    logic clk_level;   // debounced clock level
    logic clk_fall;    // accepted high-to-low change
    logic clk_rise;    // accepted low-to-high change
    logic data_level;  // synchronized data line

    modport sync (
        output clk_level, clk_fall, clk_rise, data_level
    );

    modport host (
        input  clk_level, clk_fall, clk_rise, data_level
    );

endinterface

`default_nettype wire

// File: mouse_pkg.sv
/*
 * Shared types and constants for the PS/2 mouse receiver.
 * Report carries two buttons and 9-bit signed movement only.
 * Middle button, overflow bits and wheel data are not decoded.
 */
`default_nettype none

package mouse_pkg;

    // one movement packet: three 11-bit characters
    localparam int unsigned FRAME_BITS = 33;

    // host command sent once after reset
    localparam logic [7:0] CMD_ENABLE_REPORTING = 8'hF4;

    // decoded movement report, 20 bits
    typedef struct packed {
        logic              btn_left;   // byte 0 bit 0
        logic              btn_right;  // byte 0 bit 1
        logic signed [8:0] move_x;     // sign from byte 0 bit 4
        logic signed [8:0] move_y;     // sign from byte 0 bit 5
    } mouse_report_t;

    // host protocol engine states
    typedef enum logic [1:0] {
        ST_HOLD_CLK   = 2'b00, // inhibit, clock held low
        ST_SEND_CMD   = 2'b01, // shifting command out on falls
        ST_RECEIVE    = 2'b10, // collecting device frames
        ST_FRAME_DONE = 2'b11  // one-cycle frame strobe
    } host_state_t;

endpackage

`default_nettype wire
